/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_trig_wrap
FILELIST  = trig_wrap.f
LOG       = sim.log

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: simulate clean

/* rtl/trig_command_out.sv */
`timescale 1ns/1ps

module trig_command_out (
    input  logic                sysclk_i,
    input  logic                rst_i,
    input  logic                run_start_i,
    output trig_pkg::cmd_word_t command_o,
    output logic                command_valid_o,
    output trig_pkg::trig_num_t trig_count_o,
    trig_event_if.result        evt
);

    trig_pkg::trig_num_t trig_num;
    trig_pkg::cmd_word_t cmd_next;

    // marker, source, spare, hits, metadata, number
    assign cmd_next = {
        1'b1,
        evt.src,
        1'b0,
        evt.hits,
        evt.meta,
        trig_num
    };

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            command_valid_o <= 1'b0;
            trig_num        <= '0;
        end else begin
            command_valid_o <= evt.valid;
            // run start restarts numbering from zero
            if (run_start_i) begin
                trig_num <= '0;
            end else if (evt.valid) begin
                trig_num <= trig_num + 1'b1;
            end
        end
    end

    // word built with the number before it steps
    always_ff @(posedge sysclk_i) begin
        if (evt.valid) begin
            command_o <= cmd_next;
        end
    end

    // count of commands issued since run start
    assign trig_count_o = trig_num;

endmodule

/* rtl/trig_ctrl_if.sv */
`timescale 1ns/1ps

interface trig_ctrl_if;

    trig_pkg::surf_mask_t mask;
    trig_pkg::holdoff_t   holdoff;
    logic                 running;
    // single cycle request, meta rides along
    logic                 soft_req;
    trig_pkg::meta_t      soft_meta;

    modport decode (
        output mask,
        output holdoff,
        output running,
        output soft_req,
        output soft_meta
    );

    modport execute (
        input mask,
        input holdoff,
        input running,
        input soft_req,
        input soft_meta
    );

endinterface

/* rtl/trig_event_if.sv */
`timescale 1ns/1ps

interface trig_event_if;

    // one cycle per accepted trigger
    logic                 valid;
    // src, hits and meta only mean something while valid is high
    trig_pkg::trig_src_t  src;
    trig_pkg::surf_mask_t hits;
    trig_pkg::meta_t      meta;

    modport execute (
        output valid,
        output src,
        output hits,
        output meta
    );

    modport result (
        input valid,
        input src,
        input hits,
        input meta
    );

endinterface

/* rtl/trig_pkg.sv */
package trig_pkg;

    // number of SURF trigger inputs
    localparam int NSURF = 4;

    typedef logic [15:0]      surf_word_t;
    typedef logic [NSURF-1:0] surf_mask_t;
    typedef logic [15:0]      holdoff_t;
    typedef logic [7:0]       meta_t;
    typedef logic [15:0]      trig_num_t;
    typedef logic [1:0]       trig_src_t;
    typedef logic [31:0]      cmd_word_t;
    typedef logic [7:0]       bus_adr_t;
    typedef logic [31:0]      bus_dat_t;

    // window positions after the phase pulse
    localparam int PHASE_DLY_A = 2;
    localparam int PHASE_DLY_B = 6;

    localparam holdoff_t   DEFAULT_HOLDOFF = 16'd82;
    // everything masked until software opens it up
    localparam surf_mask_t DEFAULT_MASK    = {NSURF{1'b1}};

    // register blocks, picked by address bits 7:6
    localparam logic [1:0] BLK_RUN   = 2'd0;
    localparam logic [1:0] BLK_TRIG  = 2'd1;
    localparam logic [1:0] BLK_RSVD  = 2'd2;
    localparam logic [1:0] BLK_COUNT = 2'd3;

    // registers inside the trigger block
    localparam logic [5:0] REG_MASK    = 6'd0;
    localparam logic [5:0] REG_HOLDOFF = 6'd1;
    localparam logic [5:0] REG_SOFT    = 6'd2;

    localparam trig_src_t SRC_SURF = 2'd1;
    localparam trig_src_t SRC_SOFT = 2'd2;

    // top bit of a SURF word marks a trigger
    localparam int SURF_FLAG_BIT = 15;

endpackage

/* rtl/trig_reg_decode.sv */
`timescale 1ns/1ps

module trig_reg_decode (
    input  logic                sysclk_i,
    input  logic                rst_i,
    input  logic                bus_stb_i,
    input  logic                bus_we_i,
    input  trig_pkg::bus_adr_t  bus_adr_i,
    input  trig_pkg::bus_dat_t  bus_dat_i,
    input  trig_pkg::trig_num_t trig_count_i,
    output trig_pkg::bus_dat_t  bus_dat_o,
    output logic                bus_ack_o,
    output logic                run_start_o,
    trig_ctrl_if.decode         ctrl
);

    logic [1:0]           blk;
    logic [5:0]           reg_idx;
    logic                 wr_run;
    logic                 wr_trig;
    trig_pkg::surf_mask_t mask_q;
    trig_pkg::holdoff_t   holdoff_q;
    logic                 running_q;
    logic                 soft_req_q;
    trig_pkg::meta_t      soft_meta_q;
    trig_pkg::bus_dat_t   rd_dat;

    // top two address bits pick the block
    assign blk     = bus_adr_i[7:6];
    assign reg_idx = bus_adr_i[5:0];

    assign wr_run  = bus_stb_i && bus_we_i && (blk == trig_pkg::BLK_RUN);
    assign wr_trig = bus_stb_i && bus_we_i && (blk == trig_pkg::BLK_TRIG);

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            bus_ack_o   <= 1'b0;
            run_start_o <= 1'b0;
            running_q   <= 1'b0;
            soft_req_q  <= 1'b0;
            mask_q      <= trig_pkg::DEFAULT_MASK;
            holdoff_q   <= trig_pkg::DEFAULT_HOLDOFF;
        end else begin
            // ack exactly one cycle after the strobe
            bus_ack_o   <= bus_stb_i;
            run_start_o <= wr_run && bus_dat_i[0];
            soft_req_q  <= wr_trig && (reg_idx == trig_pkg::REG_SOFT);
            // start wins if both bits are written together
            if (wr_run && bus_dat_i[0]) begin
                running_q <= 1'b1;
            end else if (wr_run && bus_dat_i[1]) begin
                running_q <= 1'b0;
            end
            if (wr_trig && (reg_idx == trig_pkg::REG_MASK)) begin
                mask_q <= bus_dat_i[trig_pkg::NSURF-1:0];
            end
            if (wr_trig && (reg_idx == trig_pkg::REG_HOLDOFF)) begin
                holdoff_q <= bus_dat_i[$bits(trig_pkg::holdoff_t)-1:0];
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wr_trig && (reg_idx == trig_pkg::REG_SOFT)) begin
            soft_meta_q <= bus_dat_i[$bits(trig_pkg::meta_t)-1:0];
        end
        if (bus_stb_i) begin
            bus_dat_o <= rd_dat;
        end
    end

    // readback mux, zero for anything unmapped
    always_comb begin
        rd_dat = '0;
        case (blk)
            trig_pkg::BLK_RUN: begin
                rd_dat[0] = running_q;
            end
            trig_pkg::BLK_TRIG: begin
                case (reg_idx)
                    trig_pkg::REG_MASK:    rd_dat = trig_pkg::bus_dat_t'(mask_q);
                    trig_pkg::REG_HOLDOFF: rd_dat = trig_pkg::bus_dat_t'(holdoff_q);
                    trig_pkg::REG_SOFT:    rd_dat = trig_pkg::bus_dat_t'(soft_meta_q);
                    default:               rd_dat = '0;
                endcase
            end
            trig_pkg::BLK_COUNT: begin
                rd_dat = trig_pkg::bus_dat_t'(trig_count_i);
            end
            default: begin
                rd_dat = '0;
            end
        endcase
    end

    assign ctrl.mask      = mask_q;
    assign ctrl.holdoff   = holdoff_q;
    assign ctrl.running   = running_q;
    assign ctrl.soft_req  = soft_req_q;
    assign ctrl.soft_meta = soft_meta_q;

endmodule

/* rtl/trig_window_select.sv */
`timescale 1ns/1ps

module trig_window_select (
    input  logic                                         sysclk_i,
    input  logic                                         rst_i,
    input  logic                                         sysclk_phase_i,
    input  trig_pkg::surf_word_t [trig_pkg::NSURF-1:0]  surf_dat_i,
    trig_ctrl_if.execute                                 ctrl,
    trig_event_if.execute                                evt
);

    logic [trig_pkg::PHASE_DLY_B-1:0] phase_sr;
    logic                             window;
    logic                             accept;
    logic                             surf_fire;
    logic                             soft_fire;
    trig_pkg::holdoff_t               holdoff_cnt;
    trig_pkg::surf_mask_t             flags;
    trig_pkg::surf_mask_t             hits;
    trig_pkg::meta_t                  hit_meta;
    logic                             soft_pend;
    trig_pkg::meta_t                  soft_meta_q;

    // phase pulse delay line, taps give the two windows
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase_sr <= '0;
        end else begin
            phase_sr <= {phase_sr[trig_pkg::PHASE_DLY_B-2:0], sysclk_phase_i};
        end
    end

    assign window = phase_sr[trig_pkg::PHASE_DLY_A-1] || phase_sr[trig_pkg::PHASE_DLY_B-1];
    assign accept = window && ctrl.running && (holdoff_cnt == '0);

    // walk down so the lowest index hit sets the metadata
    always_comb begin
        hit_meta = '0;
        for (int i = 0; i < trig_pkg::NSURF; i++) begin
            flags[i] = surf_dat_i[i][trig_pkg::SURF_FLAG_BIT];
        end
        hits = flags & ~ctrl.mask;
        for (int i = trig_pkg::NSURF - 1; i >= 0; i--) begin
            if (hits[i]) begin
                hit_meta = surf_dat_i[i][$bits(trig_pkg::meta_t)-1:0];
            end
        end
    end

    // SURF hits take the window, soft waits for an empty one
    assign surf_fire = accept && (hits != '0);
    assign soft_fire = accept && (hits == '0) && soft_pend;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            holdoff_cnt <= '0;
            soft_pend   <= 1'b0;
            evt.valid   <= 1'b0;
        end else begin
            evt.valid <= surf_fire || soft_fire;
            if (surf_fire || soft_fire) begin
                holdoff_cnt <= ctrl.holdoff;
            end else if (holdoff_cnt != '0) begin
                holdoff_cnt <= holdoff_cnt - 1'b1;
            end
            // a new request outranks the one being issued
            if (!ctrl.running) begin
                soft_pend <= 1'b0;
            end else if (ctrl.soft_req) begin
                soft_pend <= 1'b1;
            end else if (soft_fire) begin
                soft_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (ctrl.soft_req) begin
            soft_meta_q <= ctrl.soft_meta;
        end
        if (surf_fire) begin
            evt.src  <= trig_pkg::SRC_SURF;
            evt.hits <= hits;
            evt.meta <= hit_meta;
        end else if (soft_fire) begin
            evt.src  <= trig_pkg::SRC_SOFT;
            evt.hits <= '0;
            evt.meta <= soft_meta_q;
        end
    end

endmodule

/* rtl/trig_wrap.sv */
`timescale 1ns/1ps

module trig_wrap (
    input  logic                                        sysclk_i,
    input  logic                                        rst_i,
    // high in the first cycle of the 8 cycle command phase
    input  logic                                        sysclk_phase_i,
    input  trig_pkg::surf_word_t [trig_pkg::NSURF-1:0] surf_dat_i,
    input  logic                                        bus_stb_i,
    input  logic                                        bus_we_i,
    input  trig_pkg::bus_adr_t                          bus_adr_i,
    input  trig_pkg::bus_dat_t                          bus_dat_i,
    output trig_pkg::bus_dat_t                          bus_dat_o,
    output logic                                        bus_ack_o,
    output logic                                        runrst_o,
    output trig_pkg::cmd_word_t                         command_o,
    output logic                                        command_valid_o
);

    logic                run_start;
    trig_pkg::trig_num_t trig_count;

    trig_ctrl_if  ctrl_if ();
    trig_event_if evt_if ();

    trig_reg_decode u_decode (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .bus_stb_i    (bus_stb_i),
        .bus_we_i     (bus_we_i),
        .bus_adr_i    (bus_adr_i),
        .bus_dat_i    (bus_dat_i),
        .trig_count_i (trig_count),
        .bus_dat_o    (bus_dat_o),
        .bus_ack_o    (bus_ack_o),
        .run_start_o  (run_start),
        .ctrl         (ctrl_if.decode)
    );

    trig_window_select u_select (
        .sysclk_i       (sysclk_i),
        .rst_i          (rst_i),
        .sysclk_phase_i (sysclk_phase_i),
        .surf_dat_i     (surf_dat_i),
        .ctrl           (ctrl_if.execute),
        .evt            (evt_if.execute)
    );

    trig_command_out u_command (
        .sysclk_i        (sysclk_i),
        .rst_i           (rst_i),
        .run_start_i     (run_start),
        .command_o       (command_o),
        .command_valid_o (command_valid_o),
        .trig_count_o    (trig_count),
        .evt             (evt_if.result)
    );

    // run start doubles as the readout reset
    assign runrst_o = run_start;

endmodule

/* tests/tb_trig_wrap.sv */
`timescale 1ns/1ps

module tb_trig_wrap;

    logic sysclk_i = 1'b0, rst_i = 1'b1, sysclk_phase_i = 1'b0;
    logic bus_stb_i = 1'b0, bus_we_i = 1'b0, bus_ack_o, runrst_o, command_valid_o;
    logic random_on = 1'b0;
    int   ph_cnt = 0, timeouts = 0, fails_before = 0;
    trig_pkg::bus_adr_t  bus_adr_i = '0;
    trig_pkg::bus_dat_t  bus_dat_i = '0, bus_dat_o;
    trig_pkg::cmd_word_t command_o;
    // every SURF flagged until the random words take over
    trig_pkg::surf_word_t [trig_pkg::NSURF-1:0] surf_dat_i = {trig_pkg::NSURF{16'h8011}};

    trig_wrap UUT (.*);

    bind trig_wrap trig_wrap_assertions u_chk (.*);

    always #50 sysclk_i = ~sysclk_i;

    // phase pulse every 8 cycles, SURF words change with it
    always @(posedge sysclk_i) begin
        ph_cnt         <= (ph_cnt + 1) % 8;
        sysclk_phase_i <= (ph_cnt == 7);
        if (ph_cnt == 7 && random_on) begin
            for (int i = 0; i < trig_pkg::NSURF; i++) begin
                surf_dat_i[i] <= {($urandom % 3 == 0), 7'd0, 8'($urandom)};
            end
        end
    end

    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] dat);
        int n;
        n = 0;
        @(posedge sysclk_i);
        {bus_stb_i, bus_we_i, bus_adr_i, bus_dat_i} <= {1'b1, we, adr, dat};
        @(posedge sysclk_i);
        {bus_stb_i, bus_we_i} <= 2'b00;
        @(negedge sysclk_i);
        while (!bus_ack_o && n < 4) begin
            @(negedge sysclk_i);
            n++;
        end
        if (!bus_ack_o) begin
            $display("timeout waiting for the bus acknowledge at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic wait_commands(input int count, input int limit);
        int seen_cmds, n;
        seen_cmds = 0;
        n = 0;
        while (seen_cmds < count && n < limit) begin
            @(negedge sysclk_i);
            if (command_valid_o) seen_cmds++;
            n++;
        end
        if (seen_cmds < count) begin
            $display("timeout: only %0d of %0d commands arrived", seen_cmds, count);
            timeouts++;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge sysclk_i);
    endtask

    task automatic report_test(input string name);
        int now_fails;
        now_fails = UUT.u_chk.fail_cnt + timeouts;
        $display("test %s: %s", name, (now_fails == fails_before) ? "ok" : "FAILED");
        fails_before = now_fails;
    endtask

    initial begin
        int total;
        void'($urandom(27908));
        idle(8);
        rst_i <= 1'b0;
        // bus handshake and readback
        bus_access(1, 8'h40, 32'h0000_000a);
        bus_access(0, 8'h40, 0);
        bus_access(1, 8'h41, 32'd20);
        bus_access(0, 8'h41, 0);
        bus_access(0, 8'h85, 0);
        bus_access(0, 8'h00, 0);
        report_test("bus handshake");
        // flagged and unmasked inputs while stopped
        bus_access(1, 8'h40, 0);
        idle(40);
        bus_access(1, 8'h00, 32'h1);
        bus_access(0, 8'h00, 0);
        report_test("run control");
        random_on <= 1'b1;
        wait_commands(8, 3000);
        report_test("surf triggers");
        random_on <= 1'b0;
        bus_access(1, 8'h40, 32'hf);
        idle(60);
        bus_access(1, 8'h42, 32'h5a);
        wait_commands(1, 200);
        idle(40);
        bus_access(0, 8'hc0, 0);
        report_test("software trigger");
        bus_access(1, 8'h00, 32'h2);
        idle(60);
        bus_access(1, 8'h41, 32'd30);
        bus_access(1, 8'h40, 32'h2);
        bus_access(1, 8'h00, 32'h1);
        random_on <= 1'b1;
        wait_commands(6, 3000);
        bus_access(1, 8'h00, 32'h2);
        idle(10);
        bus_access(0, 8'hc0, 0);
        report_test("holdoff and numbering");
        total = UUT.u_chk.fail_cnt + timeouts;
        $display("tests: 5, assertion failures: %0d, timeouts: %0d",
                 UUT.u_chk.fail_cnt, timeouts);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tests/trig_wrap_assertions.sv */
`timescale 1ns/1ps

module trig_wrap_assertions (
    input logic                                        sysclk_i,
    input logic                                        rst_i,
    input logic                                        sysclk_phase_i,
    input trig_pkg::surf_word_t [trig_pkg::NSURF-1:0] surf_dat_i,
    input logic                                        bus_stb_i,
    input logic                                        bus_we_i,
    input trig_pkg::bus_adr_t                          bus_adr_i,
    input trig_pkg::bus_dat_t                          bus_dat_i,
    input trig_pkg::bus_dat_t                          bus_dat_o,
    input logic                                        bus_ack_o,
    input logic                                        runrst_o,
    input trig_pkg::cmd_word_t                         command_o,
    input logic                                        command_valid_o
);

    int                   fail_cnt = 0;
    int                   since;
    logic                 seen;
    logic [8:1]           ph_hist;
    logic                 run_m, run_d1, run_d2, start_d, rd_pend, wr_trig, soft_pend_m;
    trig_pkg::surf_mask_t mask_m, mask_d1, mask_d2, exp_hits;
    trig_pkg::holdoff_t   holdoff_m;
    trig_pkg::meta_t      soft_meta_m, exp_meta;
    trig_pkg::trig_num_t  num_m;
    trig_pkg::bus_dat_t   exp_rd, rd_now;
    trig_pkg::surf_word_t [trig_pkg::NSURF-1:0] surf_d1, surf_d2;

    assign wr_trig = bus_stb_i && bus_we_i && (bus_adr_i[7:6] == trig_pkg::BLK_TRIG);

    // expected hits and metadata for the window two cycles back
    always_comb begin
        exp_meta = '0;
        for (int i = trig_pkg::NSURF - 1; i >= 0; i--) begin
            exp_hits[i] = surf_d2[i][15] & ~mask_d2[i];
            if (exp_hits[i]) exp_meta = surf_d2[i][7:0];
        end
        if (exp_hits == '0) exp_meta = soft_meta_m;
        rd_now = '0;
        if (bus_adr_i[7:6] == trig_pkg::BLK_RUN) rd_now[0] = run_m;
        if (bus_adr_i[7:6] == trig_pkg::BLK_COUNT) rd_now = 32'(num_m + 16'(command_valid_o));
        if (bus_adr_i[7:6] == trig_pkg::BLK_TRIG) begin
            if (bus_adr_i[5:0] == 6'd0) rd_now = 32'(mask_m);
            if (bus_adr_i[5:0] == 6'd1) rd_now = 32'(holdoff_m);
            if (bus_adr_i[5:0] == 6'd2) rd_now = 32'(soft_meta_m);
        end
    end

    always_ff @(posedge sysclk_i) begin
        surf_d1 <= surf_dat_i;
        surf_d2 <= surf_d1;
        exp_rd  <= rd_now;
        if (wr_trig && bus_adr_i[5:0] == 6'd2) soft_meta_m <= bus_dat_i[7:0];
        if (rst_i) begin
            {ph_hist, run_m, run_d1, run_d2, start_d, rd_pend, seen, soft_pend_m} <= '0;
            {mask_m, mask_d1, mask_d2} <= '1;
            holdoff_m <= 16'd82;
            num_m     <= '0;
            since     <= 0;
        end else begin
            ph_hist <= {ph_hist[7:1], sysclk_phase_i};
            {run_d2, run_d1} <= {run_d1, run_m};
            {mask_d2, mask_d1} <= {mask_d1, mask_m};
            start_d <= bus_stb_i && bus_we_i && bus_adr_i[7:6] == 2'd0 && bus_dat_i[0];
            rd_pend <= bus_stb_i && !bus_we_i;
            if (bus_stb_i && bus_we_i && bus_adr_i[7:6] == 2'd0) begin
                if (bus_dat_i[0]) run_m <= 1'b1;
                else if (bus_dat_i[1]) run_m <= 1'b0;
            end
            if (wr_trig && bus_adr_i[5:0] == 6'd0) mask_m <= bus_dat_i[3:0];
            if (wr_trig && bus_adr_i[5:0] == 6'd1) holdoff_m <= bus_dat_i[15:0];
            // one software command per request while running
            if (!run_m) soft_pend_m <= 1'b0;
            else if (wr_trig && bus_adr_i[5:0] == 6'd2) soft_pend_m <= 1'b1;
            else if (command_valid_o && exp_hits == '0) soft_pend_m <= 1'b0;
            if (runrst_o) num_m <= '0;
            else if (command_valid_o) num_m <= num_m + 1'b1;
            since <= command_valid_o ? 1 : (since < 100000 ? since + 1 : since);
            if (command_valid_o) seen <= 1'b1;
        end
    end

    a_ack: assert property (@(posedge sysclk_i) disable iff (rst_i) bus_stb_i |=> bus_ack_o)
        else begin $error("bus acknowledge missing after a strobe"); fail_cnt++; end
    a_no_ack: assert property (@(posedge sysclk_i) disable iff (rst_i) !bus_stb_i |=> !bus_ack_o)
        else begin $error("bus acknowledge without a strobe"); fail_cnt++; end
    a_read: assert property (@(posedge sysclk_i) disable iff (rst_i) rd_pend |-> bus_dat_o == exp_rd)
        else begin $error("Mismatch at %0t: readback %h", $time, bus_dat_o); fail_cnt++; end
    a_runrst: assert property (@(posedge sysclk_i) disable iff (rst_i) runrst_o == start_d)
        else begin $error("Mismatch at %0t: run reset pulse", $time); fail_cnt++; end
    a_stopped: assert property (@(posedge sysclk_i) disable iff (rst_i) command_valid_o |-> run_d2)
        else begin $error("command issued while the run was stopped"); fail_cnt++; end
    a_phase: assert property (@(posedge sysclk_i) disable iff (rst_i)
            command_valid_o |-> ph_hist[4] || ph_hist[8])
        else begin $error("Mismatch at %0t: command off the phase windows", $time); fail_cnt++; end
    a_word: assert property (@(posedge sysclk_i) disable iff (rst_i) command_valid_o |->
            command_o[31] && !command_o[28] && command_o[27:24] == exp_hits
            && command_o[23:16] == exp_meta && command_o[15:0] == num_m
            && command_o[30:29] == ((exp_hits != '0) ? 2'd1 : 2'd2))
        else begin $error("Mismatch at %0t: command word %h", $time, command_o); fail_cnt++; end
    a_soft: assert property (@(posedge sysclk_i) disable iff (rst_i)
            command_valid_o && exp_hits == '0 |-> soft_pend_m)
        else begin $error("software command issued without a pending request"); fail_cnt++; end
    a_gap: assert property (@(posedge sysclk_i) disable iff (rst_i)
            command_valid_o && seen |-> since > int'(holdoff_m))
        else begin $error("Mismatch at %0t: holdoff gap %0d", $time, since); fail_cnt++; end

endmodule

/* trig_wrap.f */
rtl/trig_pkg.sv
rtl/trig_ctrl_if.sv
rtl/trig_event_if.sv
rtl/trig_reg_decode.sv
rtl/trig_window_select.sv
rtl/trig_command_out.sv
rtl/trig_wrap.sv
tests/trig_wrap_assertions.sv
tests/tb_trig_wrap.sv
